// ==== files.f ====
+incdir+include
hdl/fir_pkg.sv
hdl/coef_regs.sv
hdl/sym_delay_line.sv
hdl/tap_multiply.sv
hdl/tap_sum.sv
hdl/pulse_shaping_filter.sv
tb/tb_pulse_shaping_filter.sv

// ==== hdl/coef_regs.sv ====
`include "fir_defines.svh"

module coef_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 coef_we,
	input  fir_pkg::coef_addr_t  coef_addr,
	input  fir_pkg::coef_t       coef_data,
	output fir_pkg::coef_t       coefs [`FIR_NUM_COEFS]
);

	localparam int NUM_COEFS = `FIR_NUM_COEFS;

	logic addr_ok;
	logic wr_en;

	// Addresses past the last unique tap are dropped
	assign addr_ok = (int'(coef_addr) < NUM_COEFS);
	assign wr_en = coef_we && addr_ok;

	// Filter is silent until the host loads the bank
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_COEFS; i++)
			begin
				coefs[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			coefs[coef_addr] <= coef_data;
		end
	end

endmodule

// ==== hdl/fir_pkg.sv ====
`include "fir_defines.svh"

package fir_pkg;

	// Input sample, scaled tap product and filter output
	typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;

	// Sum of two samples sharing a coefficient
	typedef logic signed [`FIR_PRESUM_W-1:0] presum_t;

	// Programmable tap weight
	typedef logic signed [`FIR_COEF_W-1:0] coef_t;

	// Host side index into the coefficient bank
	typedef logic [`FIR_COEF_ADDR_W-1:0] coef_addr_t;

	// Full precision pre-sum times coefficient, before rescaling
	typedef logic signed [`FIR_PRESUM_W+`FIR_COEF_W-1:0] mult_t;

endpackage

// ==== hdl/pulse_shaping_filter.sv ====
`include "fir_defines.svh"

module pulse_shaping_filter (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 sam_clk_en,
	input  logic                 coef_we,
	input  fir_pkg::coef_addr_t  coef_addr,
	input  fir_pkg::coef_t       coef_data,
	input  fir_pkg::sample_t     x_in,
	output fir_pkg::sample_t     y
);

	fir_pkg::coef_t   coefs [`FIR_NUM_COEFS];
	fir_pkg::presum_t presums [`FIR_NUM_COEFS];
	fir_pkg::sample_t products [`FIR_NUM_COEFS];

	// Host programmed weights, one per mirrored pair plus the centre
	coef_regs u_coef_regs (
		.clk       (clk),
		.reset     (reset),
		.coef_we   (coef_we),
		.coef_addr (coef_addr),
		.coef_data (coef_data),
		.coefs     (coefs)
	);

	sym_delay_line u_sym_delay_line (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.x_in       (x_in),
		.presums    (presums)
	);

	tap_multiply u_tap_multiply (
		.presums  (presums),
		.coefs    (coefs),
		.products (products)
	);

	// Registered output, one strobe behind the delay line
	tap_sum u_tap_sum (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.products   (products),
		.y          (y)
	);

endmodule

// ==== hdl/sym_delay_line.sv ====
`include "fir_defines.svh"

module sym_delay_line (
	input  logic                clk,
	input  logic                reset,
	input  logic                sam_clk_en,
	input  fir_pkg::sample_t    x_in,
	output fir_pkg::presum_t    presums [`FIR_NUM_COEFS]
);

	localparam int NUM_TAPS = `FIR_NUM_TAPS;
	localparam int NUM_COEFS = `FIR_NUM_COEFS;
	localparam int CENTRE = (NUM_TAPS - 1) / 2;

	fir_pkg::sample_t x [NUM_TAPS];

	// Slot 0 holds the newest sample
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_TAPS; i++)
			begin
				x[i] <= '0;
			end
		end
		else if (sam_clk_en)
		begin
			x[0] <= x_in;
			for (int i = 1; i < NUM_TAPS; i++)
			begin
				x[i] <= x[i-1];
			end
		end
	end

	// Taps k and N-1-k share a weight, so add them before the multiply
	always_comb
	begin
		for (int k = 0; k < NUM_COEFS - 1; k++)
		begin
			presums[k] = fir_pkg::presum_t'(x[k]) + fir_pkg::presum_t'(x[NUM_TAPS-1-k]);
		end
		// Centre tap has no partner
		presums[NUM_COEFS-1] = fir_pkg::presum_t'(x[CENTRE]);
	end

endmodule

// ==== hdl/tap_multiply.sv ====
`include "fir_defines.svh"

module tap_multiply (
	input  fir_pkg::presum_t   presums [`FIR_NUM_COEFS],
	input  fir_pkg::coef_t     coefs [`FIR_NUM_COEFS],
	output fir_pkg::sample_t   products [`FIR_NUM_COEFS]
);

	localparam int NUM_COEFS = `FIR_NUM_COEFS;

	fir_pkg::mult_t full [NUM_COEFS];
	fir_pkg::mult_t scaled [NUM_COEFS];

	always_comb
	begin
		for (int k = 0; k < NUM_COEFS; k++)
		begin
			// 2s17 times 1s17 is exact at full width
			full[k] = fir_pkg::mult_t'(presums[k]) * fir_pkg::mult_t'(coefs[k]);

			// Drop the coefficient fraction, rounding toward minus infinity
			scaled[k] = full[k] >>> `FIR_FRAC_BITS;

			// Back to 1s17, upper bits wrap
			products[k] = scaled[k][`FIR_SAMPLE_W-1:0];
		end
	end

endmodule

// ==== hdl/tap_sum.sv ====
`include "fir_defines.svh"

module tap_sum (
	input  logic                clk,
	input  logic                reset,
	input  logic                sam_clk_en,
	input  fir_pkg::sample_t    products [`FIR_NUM_COEFS],
	output fir_pkg::sample_t    y
);

	localparam int NUM_COEFS = `FIR_NUM_COEFS;
	localparam int LEVELS = $clog2(NUM_COEFS);
	localparam int WIDTH = 2 ** LEVELS;

	// Row 0 is the padded product vector, row LEVELS holds the total
	fir_pkg::sample_t tree [LEVELS+1][WIDTH];
	fir_pkg::sample_t total;

	// Balanced adder tree, every stage wraps at sample width
	always_comb
	begin
		tree = '{default: '0};
		for (int i = 0; i < NUM_COEFS; i++)
		begin
			tree[0][i] = products[i];
		end
		for (int l = 0; l < LEVELS; l++)
		begin
			for (int i = 0; i < (WIDTH >> (l + 1)); i++)
			begin
				tree[l+1][i] = tree[l][2*i] + tree[l][2*i+1];
			end
		end
	end

	assign total = tree[LEVELS][0];

	// Output updates only on sample strobes
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			y <= '0;
		end
		else if (sam_clk_en)
		begin
			y <= total;
		end
	end

endmodule

// ==== include/fir_defines.svh ====
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// Sample and product format, 1s17
`define FIR_SAMPLE_W 18

// Mirrored pairs need one extra integer bit, 2s17
`define FIR_PRESUM_W 19

// Coefficient format, 1s17
`define FIR_COEF_W 18
`define FIR_FRAC_BITS 17

// Filter length, odd so there is a lone centre tap
`define FIR_NUM_TAPS 21
`define FIR_NUM_COEFS ((`FIR_NUM_TAPS + 1) / 2)

// Wide enough to index every unique coefficient
`define FIR_COEF_ADDR_W 4

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the pulse shaping filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_pulse_shaping_filter -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_pulse_shaping_filter > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qF "** PASS **" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tb/tb_pulse_shaping_filter.sv ====
`include "fir_defines.svh"

module tb_pulse_shaping_filter;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TAPS = `FIR_NUM_TAPS;
	localparam int NUM_COEFS = `FIR_NUM_COEFS;
	localparam int CENTRE = (NUM_TAPS - 1) / 2;

	logic                clk = 1'b0;
	logic                reset;
	logic                sam_clk_en;
	logic                coef_we;
	fir_pkg::coef_addr_t coef_addr;
	fir_pkg::coef_t      coef_data;
	fir_pkg::sample_t    x_in;
	fir_pkg::sample_t    y;

	// Reference model state
	fir_pkg::sample_t model_x [NUM_TAPS];
	fir_pkg::coef_t   model_coef [NUM_COEFS];
	fir_pkg::sample_t model_y;

	logic [31:0] lfsr_state = 32'hf79f;

	pulse_shaping_filter uut (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.coef_we    (coef_we),
		.coef_addr  (coef_addr),
		.coef_data  (coef_data),
		.x_in       (x_in),
		.y          (y)
	);

	always #20 clk = ~clk;

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_sample(input string name, input fir_pkg::sample_t expected,
		input fir_pkg::sample_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_coef_effect(input string label, input fir_pkg::sample_t expected,
		input fir_pkg::sample_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] t=%0t y (%s) expected %0d actual %0d", $time, label, expected,
				actual);
			abort_run();
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic fir_pkg::sample_t random_sample();
		logic [31:0] r;
		r = random_bits(`FIR_SAMPLE_W);
		return r[`FIR_SAMPLE_W-1:0];
	endfunction

	function automatic fir_pkg::coef_t random_coef();
		logic [31:0] r;
		r = random_bits(`FIR_COEF_W);
		return r[`FIR_COEF_W-1:0];
	endfunction

	// Expected sum from the current model delay line and weights
	function automatic fir_pkg::sample_t model_sum();
		longint acc;
		longint pre;
		longint prod;
		acc = 0;
		for (int k = 0; k < NUM_COEFS; k++)
		begin
			if (k == NUM_COEFS - 1)
				pre = longint'(model_x[CENTRE]);
			else
				pre = longint'(model_x[k]) + longint'(model_x[NUM_TAPS-1-k]);
			prod = (pre * longint'(model_coef[k])) >>> `FIR_FRAC_BITS;
			acc = acc + prod;
		end
		// Low bits of the total equal the wrapped sum of wrapped products
		return acc[`FIR_SAMPLE_W-1:0];
	endfunction

	task automatic clear_model();
		for (int i = 0; i < NUM_TAPS; i++)
			model_x[i] = '0;
		for (int k = 0; k < NUM_COEFS; k++)
			model_coef[k] = '0;
		model_y = '0;
	endtask

	task automatic shift_model(input fir_pkg::sample_t x);
		for (int i = NUM_TAPS - 1; i > 0; i--)
			model_x[i] = model_x[i-1];
		model_x[0] = x;
	endtask

	// Called on a falling edge, returns on the next one
	task automatic drive_cycle(input logic en, input fir_pkg::sample_t x);
		sam_clk_en = en;
		x_in = x;
		if (en)
		begin
			model_y = model_sum();
			shift_model(x);
		end
		@(posedge clk);
		@(negedge clk);
		sam_clk_en = 1'b0;
	endtask

	task automatic strobe_checked(input fir_pkg::sample_t x);
		drive_cycle(1'b1, x);
		check_sample("y", model_y, y);
	endtask

	task automatic idle_checked(input fir_pkg::sample_t x);
		drive_cycle(1'b0, x);
		check_sample("y", model_y, y);
	endtask

	task automatic write_coef(input fir_pkg::coef_addr_t addr, input fir_pkg::coef_t data);
		coef_we = 1'b1;
		coef_addr = addr;
		coef_data = data;
		@(posedge clk);
		@(negedge clk);
		coef_we = 1'b0;
		// Out of range writes are dropped by the filter
		if (int'(addr) < NUM_COEFS)
			model_coef[int'(addr)] = data;
	endtask

	task automatic write_random_coefs();
		for (int k = 0; k < NUM_COEFS; k++)
			write_coef(fir_pkg::coef_addr_t'(k), random_coef());
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		sam_clk_en = 1'b0;
		coef_we = 1'b0;
		clear_model();
		for (int i = 0; i < 4; i++)
			@(negedge clk);
		check_sample("y", '0, y);
		reset = 1'b0;
	endtask

	task automatic test_reset_output();
		fir_pkg::sample_t x;
		for (int i = 0; i < 8; i++)
		begin
			x = random_sample();
			if (x == '0)
				x = 18'sd1;
			drive_cycle(1'b1, x);
			check_sample("y", '0, y);
		end
	endtask

	task automatic test_impulse();
		fir_pkg::coef_t   imp_coef [NUM_COEFS];
		fir_pkg::sample_t expected;
		int               m;
		for (int k = 0; k < NUM_COEFS; k++)
		begin
			imp_coef[k] = fir_pkg::coef_t'((k + 1) * 4099 * ((k % 2 == 0) ? 1 : -1));
			write_coef(fir_pkg::coef_addr_t'(k), imp_coef[k]);
		end
		// Flush the delay line
		for (int i = 0; i < NUM_TAPS; i++)
			strobe_checked('0);
		drive_cycle(1'b1, fir_pkg::sample_t'(32768));
		check_coef_effect("impulse", '0, y);
		for (int j = 1; j <= NUM_TAPS + 1; j++)
		begin
			drive_cycle(1'b1, '0);
			if (j > NUM_TAPS)
				expected = '0;
			else
			begin
				m = (j - 1 <= CENTRE) ? j - 1 : NUM_TAPS - j;
				expected = fir_pkg::sample_t'((longint'(imp_coef[m]) * 32768) >>>
					`FIR_FRAC_BITS);
			end
			check_coef_effect("impulse", expected, y);
		end
	endtask

	task automatic test_hold();
		for (int i = 0; i < 6; i++)
			strobe_checked(random_sample());
		for (int i = 0; i < 12; i++)
			idle_checked(random_sample());
		for (int i = 0; i < 6; i++)
			strobe_checked(random_sample());
	endtask

	task automatic test_random_stream();
		logic [31:0] gap;
		write_random_coefs();
		for (int i = 0; i < 200; i++)
		begin
			gap = random_bits(2);
			for (int g = 0; g < int'(gap); g++)
				idle_checked(random_sample());
			strobe_checked(random_sample());
		end
	endtask

	task automatic test_coef_rewrite();
		for (int i = 0; i < 10; i++)
			strobe_checked(random_sample());
		write_coef(fir_pkg::coef_addr_t'(3), random_coef());
		write_coef(fir_pkg::coef_addr_t'(NUM_COEFS - 1), random_coef());
		for (int i = 0; i < 15; i++)
		begin
			drive_cycle(1'b1, random_sample());
			check_coef_effect("rewrite", model_y, y);
		end
		// Addresses past the bank must not alias onto real entries
		write_coef(fir_pkg::coef_addr_t'(11), 18'sh1ffff);
		write_coef(fir_pkg::coef_addr_t'(13), 18'sh1ffff);
		write_coef(fir_pkg::coef_addr_t'(15), 18'sh20000);
		for (int i = 0; i < 15; i++)
		begin
			drive_cycle(1'b1, random_sample());
			check_coef_effect("out of range write", model_y, y);
		end
	endtask

	task automatic test_mid_stream_reset();
		for (int i = 0; i < 8; i++)
			strobe_checked(random_sample());
		apply_reset();
		// Weights are zero again, so live samples must give a silent output
		for (int i = 0; i < 4; i++)
			strobe_checked(random_sample());
		write_random_coefs();
		idle_checked('0);
		for (int i = 0; i < 30; i++)
			strobe_checked(random_sample());
	endtask

	initial
	begin
		reset = 1'b1;
		sam_clk_en = 1'b0;
		coef_we = 1'b0;
		coef_addr = '0;
		coef_data = '0;
		x_in = '0;
		clear_model();
		@(negedge clk);
		apply_reset();
		test_reset_output();
		test_impulse();
		test_hold();
		test_random_stream();
		test_coef_rewrite();
		test_mid_stream_reset();
		$display("** PASS **");
		$finish;
	end

endmodule
